//--- Bender.yml
package:
  name: radio_core

sources:
  - files:
      - rtl/radio_core_pkg.sv
      - rtl/ctrl_demux.sv
      - rtl/ctrl_proc.sv
      - rtl/core_settings.sv
      - rtl/pps_select.sv
      - rtl/resp_mux.sv
      - rtl/radio_core.sv
  - target: test
    files:
      - tests/radio_core_tb.sv

//--- radio_core.f
rtl/radio_core_pkg.sv
rtl/ctrl_demux.sv
rtl/ctrl_proc.sv
rtl/core_settings.sv
rtl/pps_select.sv
rtl/resp_mux.sv
rtl/radio_core.sv
tests/radio_core_tb.sv

//--- rtl/core_settings.sv
// registers take a write the cycle after the strobe; lock bits pass a 2-flop synchronizer
`timescale 1ns/1ps
`default_nettype none

module core_settings (
    input  wire                                 i_radio_clk,
    input  wire                                 i_bus_rst,
    input  radio_core_pkg::set_bus_t            i_set,
    input  wire [31:0]                          i_rb_misc,
    input  wire [1:0]                           i_lock_signals,
    output logic [31:0]                         o_misc_outs,
    output radio_core_pkg::pps_src_e            o_pps_select,
    output logic [radio_core_pkg::WORD_W-1:0]   o_readback
);

    radio_core_pkg::rb_sel_e rb_sel_q;
    logic [1:0]              lock_meta_q;
    logic [1:0]              lock_sync_q;

    ////////////////////////////////////////////////////////////////////////////
    // address decoded registers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            o_misc_outs  <= 32'd0;
            rb_sel_q     <= radio_core_pkg::RB_COMPAT;
            o_pps_select <= radio_core_pkg::PPS_GPSDO;
        end else if (i_set.stb) begin
            case (i_set.addr)
                radio_core_pkg::SR_MISC:     o_misc_outs  <= i_set.data;
                radio_core_pkg::SR_READBACK: rb_sel_q     <= radio_core_pkg::rb_sel_e'(i_set.data[1:0]);
                radio_core_pkg::SR_SYNC:     o_pps_select <= radio_core_pkg::pps_src_e'(i_set.data[1:0]);
                default: ;
            endcase
        end
    end

    // front-end lock bits, asynchronous to us
    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            lock_meta_q <= 2'b00;
            lock_sync_q <= 2'b00;
        end else begin
            lock_meta_q <= i_lock_signals;
            lock_sync_q <= lock_meta_q;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // readback select
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (rb_sel_q)
            radio_core_pkg::RB_COMPAT: o_readback = {radio_core_pkg::COMPAT_SIGNATURE,
                                                     radio_core_pkg::COMPAT_MAJOR,
                                                     radio_core_pkg::COMPAT_MINOR};
            radio_core_pkg::RB_MISC:   o_readback = {32'd0, o_misc_outs};
            radio_core_pkg::RB_STATUS: o_readback = {32'd0, i_rb_misc};
            default:                   o_readback = {62'd0, lock_sync_q};
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/ctrl_demux.sv
// first word of every packet must be a header; route holds until last, nothing is buffered
`timescale 1ns/1ps
`default_nettype none

module ctrl_demux (
    input  wire                          i_radio_clk,
    input  wire                          i_bus_rst,
    input  radio_core_pkg::stream_beat_t i_ctrl,
    output logic                         o_ctrl_ready,
    output radio_core_pkg::stream_beat_t o_core,
    input  wire                          i_core_ready,
    output radio_core_pkg::stream_beat_t o_loop,
    input  wire                          i_loop_ready
);

    logic                   mid_pkt_q;
    radio_core_pkg::route_e route_q;
    radio_core_pkg::route_e hdr_route;
    radio_core_pkg::route_e route;
    logic [7:0]             sid_masked;
    logic                   in_xfer;

    // decode straight off the header word
    always_comb begin
        sid_masked = i_ctrl.data[7:0] & radio_core_pkg::SID_MASK;
        if (sid_masked == (radio_core_pkg::SID_CORE & radio_core_pkg::SID_MASK)) begin
            hdr_route = radio_core_pkg::ROUTE_CORE;
        end else if (sid_masked == (radio_core_pkg::SID_LOOP & radio_core_pkg::SID_MASK)) begin
            hdr_route = radio_core_pkg::ROUTE_LOOP;
        end else begin
            hdr_route = radio_core_pkg::ROUTE_DISCARD;
        end
    end

    assign route = mid_pkt_q ? route_q : hdr_route;

    always_comb begin
        case (route)
            radio_core_pkg::ROUTE_CORE: o_ctrl_ready = i_core_ready;
            radio_core_pkg::ROUTE_LOOP: o_ctrl_ready = i_loop_ready;
            // discard sink swallows everything
            default:                    o_ctrl_ready = 1'b1;
        endcase
    end

    assign o_core = '{valid: i_ctrl.valid && (route == radio_core_pkg::ROUTE_CORE),
                      last:  i_ctrl.last,
                      data:  i_ctrl.data};
    assign o_loop = '{valid: i_ctrl.valid && (route == radio_core_pkg::ROUTE_LOOP),
                      last:  i_ctrl.last,
                      data:  i_ctrl.data};

    assign in_xfer = i_ctrl.valid && o_ctrl_ready;

    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            mid_pkt_q <= 1'b0;
            route_q   <= radio_core_pkg::ROUTE_DISCARD;
        end else if (in_xfer) begin
            mid_pkt_q <= !i_ctrl.last;
            route_q   <= route;
        end
    end

    // one route per packet, from a stalled header through to the last word
    a_route_hold: assert property (@(posedge i_radio_clk) disable iff (i_bus_rst)
        (i_ctrl.valid && !(in_xfer && i_ctrl.last)) |=> $stable(route));

endmodule

`default_nettype wire

//--- rtl/ctrl_proc.sv
// one two-word packet in flight; extra command words are drained and ignored, only writes supported
`timescale 1ns/1ps
`default_nettype none

module ctrl_proc (
    input  wire                                 i_radio_clk,
    input  wire                                 i_bus_rst,
    input  radio_core_pkg::stream_beat_t        i_ctrl,
    output logic                                o_ctrl_ready,
    output radio_core_pkg::set_bus_t            o_set,
    input  wire [radio_core_pkg::WORD_W-1:0]    i_readback,
    output radio_core_pkg::stream_beat_t        o_resp,
    input  wire                                 i_resp_ready
);

    radio_core_pkg::proc_state_e state_q;
    logic                          ready_q;
    logic [7:0]                    seq_q;
    logic                          set_stb_q;
    logic [7:0]                    set_addr_q;
    logic [31:0]                   set_data_q;
    logic                          resp_valid_q;
    logic                          resp_last_q;
    logic [radio_core_pkg::WORD_W-1:0] resp_data_q;
    logic                          ctrl_xfer;
    logic                          resp_xfer;

    assign o_ctrl_ready = ready_q;
    assign ctrl_xfer    = i_ctrl.valid && ready_q;
    assign resp_xfer    = resp_valid_q && i_resp_ready;

    assign o_set  = '{stb: set_stb_q, addr: set_addr_q, data: set_data_q};
    assign o_resp = '{valid: resp_valid_q, last: resp_last_q, data: resp_data_q};

    ////////////////////////////////////////////////////////////////////////////
    // control FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            state_q      <= radio_core_pkg::ST_HEADER;
            ready_q      <= 1'b0;
            set_stb_q    <= 1'b0;
            resp_valid_q <= 1'b0;
            resp_last_q  <= 1'b0;
        end else begin
            set_stb_q <= 1'b0;
            case (state_q)
                radio_core_pkg::ST_HEADER: begin
                    if (!ready_q) begin
                        ready_q <= 1'b1;
                    end else if (ctrl_xfer && !i_ctrl.last) begin
                        state_q <= radio_core_pkg::ST_COMMAND;
                    end
                end
                radio_core_pkg::ST_COMMAND: begin
                    if (ctrl_xfer) begin
                        if (i_ctrl.last) begin
                            set_stb_q <= 1'b1;
                            ready_q   <= 1'b0;
                            state_q   <= radio_core_pkg::ST_RESP_HDR;
                        end else begin
                            state_q <= radio_core_pkg::ST_DRAIN;
                        end
                    end
                end
                radio_core_pkg::ST_DRAIN: begin
                    // write goes out once the packet is fully consumed
                    if (ctrl_xfer && i_ctrl.last) begin
                        set_stb_q <= 1'b1;
                        ready_q   <= 1'b0;
                        state_q   <= radio_core_pkg::ST_RESP_HDR;
                    end
                end
                radio_core_pkg::ST_RESP_HDR: begin
                    if (!resp_valid_q) begin
                        resp_valid_q <= 1'b1;
                        resp_last_q  <= 1'b0;
                    end else if (resp_xfer) begin
                        resp_last_q <= 1'b1;
                        state_q     <= radio_core_pkg::ST_RESP_DATA;
                    end
                end
                radio_core_pkg::ST_RESP_DATA: begin
                    if (resp_xfer) begin
                        resp_valid_q <= 1'b0;
                        resp_last_q  <= 1'b0;
                        ready_q      <= 1'b1;
                        state_q      <= radio_core_pkg::ST_HEADER;
                    end
                end
                default: state_q <= radio_core_pkg::ST_HEADER;
            endcase
        end
    end

    // payload
    always_ff @(posedge i_radio_clk) begin
        if (state_q == radio_core_pkg::ST_HEADER && ctrl_xfer) begin
            seq_q <= i_ctrl.data[23:16];
        end
        if (state_q == radio_core_pkg::ST_COMMAND && ctrl_xfer) begin
            set_addr_q <= i_ctrl.data[39:32];
            set_data_q <= i_ctrl.data[31:0];
        end
        if (state_q == radio_core_pkg::ST_RESP_HDR) begin
            if (!resp_valid_q) begin
                resp_data_q <= {40'd0, seq_q, 8'd0, radio_core_pkg::SID_RESP};
            end else if (resp_xfer) begin
                // settings have taken the write by now
                resp_data_q <= i_readback;
            end
        end
    end

    a_stb_single: assert property (@(posedge i_radio_clk) disable iff (i_bus_rst)
        o_set.stb |=> !o_set.stb);

    a_resp_hold: assert property (@(posedge i_radio_clk) disable iff (i_bus_rst)
        (o_resp.valid && !i_resp_ready) |=> $stable(o_resp));

endmodule

`default_nettype wire

//--- rtl/pps_select.sv
// pps inputs are asynchronous; output lags the chosen input by two clocks, none gives zero
`timescale 1ns/1ps
`default_nettype none

module pps_select (
    input  wire                      i_radio_clk,
    input  wire                      i_bus_rst,
    input  wire                      i_pps_gpsdo,
    input  wire                      i_pps_ext,
    input  wire                      i_pps_int,
    input  radio_core_pkg::pps_src_e i_src,
    output logic                     o_pps
);

    // bit order: int, ext, gpsdo
    logic [2:0] pps_meta_q;
    logic [2:0] pps_sync_q;

    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            pps_meta_q <= 3'b000;
            pps_sync_q <= 3'b000;
        end else begin
            pps_meta_q <= {i_pps_int, i_pps_ext, i_pps_gpsdo};
            pps_sync_q <= pps_meta_q;
        end
    end

    always_comb begin
        case (i_src)
            radio_core_pkg::PPS_GPSDO: o_pps = pps_sync_q[0];
            radio_core_pkg::PPS_EXT:   o_pps = pps_sync_q[1];
            radio_core_pkg::PPS_INT:   o_pps = pps_sync_q[2];
            default:                   o_pps = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/radio_core.sv
// one clock domain; only SID 0x4x reaches the processor, 0x2x loops back, anything else is dropped
`timescale 1ns/1ps
`default_nettype none

module radio_core (
    input  wire                          i_radio_clk,
    input  wire                          i_bus_rst,
    input  radio_core_pkg::stream_beat_t i_ctrl,
    output logic                         o_ctrl_ready,
    output radio_core_pkg::stream_beat_t o_resp,
    input  wire                          i_resp_ready,
    input  wire                          i_pps_gpsdo,
    input  wire                          i_pps_ext,
    input  wire                          i_pps_int,
    output logic                         o_pps,
    output radio_core_pkg::pps_src_e     o_pps_select,
    input  wire [31:0]                   i_rb_misc,
    output logic [31:0]                  o_misc_outs,
    input  wire [1:0]                    i_lock_signals
);

    radio_core_pkg::stream_beat_t      core_ctrl;
    logic                              core_ctrl_ready;
    radio_core_pkg::stream_beat_t      loop_beat;
    logic                              loop_ready;
    radio_core_pkg::stream_beat_t      proc_resp;
    logic                              proc_resp_ready;
    radio_core_pkg::set_bus_t          set_bus;
    logic [radio_core_pkg::WORD_W-1:0] readback;

    ////////////////////////////////////////////////////////////////////////////
    // routing
    ////////////////////////////////////////////////////////////////////////////
    ctrl_demux demux0 (
        .i_radio_clk(i_radio_clk), .i_bus_rst(i_bus_rst),
        .i_ctrl(i_ctrl), .o_ctrl_ready(o_ctrl_ready),
        .o_core(core_ctrl), .i_core_ready(core_ctrl_ready),
        .o_loop(loop_beat), .i_loop_ready(loop_ready)
    );

    // spare radio slot loops straight into the mux
    resp_mux mux0 (
        .i_radio_clk(i_radio_clk), .i_bus_rst(i_bus_rst),
        .i_a(proc_resp), .o_a_ready(proc_resp_ready),
        .i_b(loop_beat), .o_b_ready(loop_ready),
        .o_resp(o_resp), .i_resp_ready(i_resp_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // control and settings
    ////////////////////////////////////////////////////////////////////////////
    ctrl_proc proc0 (
        .i_radio_clk(i_radio_clk), .i_bus_rst(i_bus_rst),
        .i_ctrl(core_ctrl), .o_ctrl_ready(core_ctrl_ready),
        .o_set(set_bus), .i_readback(readback),
        .o_resp(proc_resp), .i_resp_ready(proc_resp_ready)
    );

    core_settings settings0 (
        .i_radio_clk(i_radio_clk), .i_bus_rst(i_bus_rst),
        .i_set(set_bus), .i_rb_misc(i_rb_misc), .i_lock_signals(i_lock_signals),
        .o_misc_outs(o_misc_outs), .o_pps_select(o_pps_select), .o_readback(readback)
    );

    pps_select pps0 (
        .i_radio_clk(i_radio_clk), .i_bus_rst(i_bus_rst),
        .i_pps_gpsdo(i_pps_gpsdo), .i_pps_ext(i_pps_ext), .i_pps_int(i_pps_int),
        .i_src(o_pps_select), .o_pps(o_pps)
    );

endmodule

`default_nettype wire

//--- rtl/radio_core_pkg.sv
// single radio_clk domain; SIDs are matched on the upper nibble only, settings bus is 8-bit addressed
`default_nettype none

package radio_core_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // stream and routing constants
    ////////////////////////////////////////////////////////////////////////////
    localparam int WORD_W = 64;

    localparam logic [7:0] SID_MASK = 8'hf0;
    localparam logic [7:0] SID_CORE = 8'h40;
    localparam logic [7:0] SID_LOOP = 8'h20;
    // source SID stamped on processor responses
    localparam logic [7:0] SID_RESP = 8'h04;

    // settings addresses
    localparam logic [7:0] SR_MISC     = 8'd16;
    localparam logic [7:0] SR_READBACK = 8'd32;
    localparam logic [7:0] SR_SYNC     = 8'd48;

    // readback word 0
    localparam logic [31:0] COMPAT_SIGNATURE = 32'hace0ba5e;
    localparam logic [15:0] COMPAT_MAJOR     = 16'h0010;
    localparam logic [15:0] COMPAT_MINOR     = 16'h0000;

    ////////////////////////////////////////////////////////////////////////////
    // bundled types
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic              valid;
        logic              last;
        logic [WORD_W-1:0] data;
    } stream_beat_t;

    typedef struct packed {
        logic        stb;
        logic [7:0]  addr;
        logic [31:0] data;
    } set_bus_t;

    typedef enum logic [1:0] {
        ROUTE_CORE,
        ROUTE_LOOP,
        ROUTE_DISCARD
    } route_e;

    typedef enum logic [1:0] {
        RB_COMPAT = 2'd0,
        RB_MISC   = 2'd1,
        RB_STATUS = 2'd2,
        RB_LOCK   = 2'd3
    } rb_sel_e;

    typedef enum logic [1:0] {
        PPS_GPSDO = 2'd0,
        PPS_EXT   = 2'd1,
        PPS_INT   = 2'd2,
        PPS_NONE  = 2'd3
    } pps_src_e;

    typedef enum logic [2:0] {
        ST_HEADER,
        ST_COMMAND,
        ST_RESP_HDR,
        ST_RESP_DATA,
        ST_DRAIN
    } proc_state_e;

endpackage

`default_nettype wire

//--- rtl/resp_mux.sv
// whole packets only; round robin between a and b, grant is held until the last word moves
`timescale 1ns/1ps
`default_nettype none

module resp_mux (
    input  wire                          i_radio_clk,
    input  wire                          i_bus_rst,
    input  radio_core_pkg::stream_beat_t i_a,
    output logic                         o_a_ready,
    input  radio_core_pkg::stream_beat_t i_b,
    output logic                         o_b_ready,
    output radio_core_pkg::stream_beat_t o_resp,
    input  wire                          i_resp_ready
);

    // grant_b_q also records who was served last
    logic grant_b_q;
    logic active_q;
    logic pick_b;
    logic sel_b;
    logic out_xfer;

    always_comb begin
        if (i_a.valid && i_b.valid) begin
            pick_b = !grant_b_q;
        end else begin
            pick_b = i_b.valid;
        end
        sel_b = active_q ? grant_b_q : pick_b;
    end

    assign o_resp    = sel_b ? i_b : i_a;
    assign o_a_ready = i_resp_ready && !sel_b && i_a.valid;
    assign o_b_ready = i_resp_ready && sel_b && i_b.valid;
    assign out_xfer  = o_resp.valid && i_resp_ready;

    // grant is taken as soon as a word is offered, so a stalled first word keeps it
    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            grant_b_q <= 1'b1;
            active_q  <= 1'b0;
        end else if (o_resp.valid) begin
            grant_b_q <= sel_b;
            active_q  <= !(out_xfer && o_resp.last);
        end
    end

    a_grant_hold: assert property (@(posedge i_radio_clk) disable iff (i_bus_rst)
        (o_resp.valid && !(out_xfer && o_resp.last)) |=> $stable(sel_b));

endmodule

`default_nettype wire

//--- tests/radio_core_tb.sv
// entries run one at a time, so responses come back in table order; the watchdog bounds every wait
`timescale 1ns/1ps
`default_nettype none

module radio_core_tb;

    typedef enum logic [1:0] {K_CORE, K_LOOP, K_UNKNOWN} kind_e;

    typedef struct packed {
        kind_e       kind;
        logic [7:0]  sid;
        logic [7:0]  seq;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [1:0]  lock;
        logic [2:0]  pps;      // {int, ext, gpsdo}
        logic        rand_rdy;
        logic        exp_pps;
    } entry_t;

    localparam int          NUM_TESTS   = 18;
    localparam logic [7:0]  A_MISC      = radio_core_pkg::SR_MISC;
    localparam logic [7:0]  A_RB        = radio_core_pkg::SR_READBACK;
    localparam logic [7:0]  A_SYNC      = radio_core_pkg::SR_SYNC;
    localparam logic [31:0] STATUS_WORD = 32'h5a5a_0084;

    logic                         radio_clk;
    logic                         bus_rst;
    radio_core_pkg::stream_beat_t ctrl_beat;
    logic                         ctrl_ready;
    radio_core_pkg::stream_beat_t resp_beat;
    logic                         resp_ready;
    logic                         pps_gpsdo;
    logic                         pps_ext;
    logic                         pps_int;
    logic                         pps_out;
    radio_core_pkg::pps_src_e     pps_sel;
    logic [31:0]                  misc_outs;
    logic [1:0]                   lock_signals;

    entry_t                  tbl [NUM_TESTS];
    logic [31:0]             lcg_state;
    logic                    rand_ready;
    int                      errors;
    int                      checks;
    // reference model of the settings registers
    logic [31:0]             m_misc;
    radio_core_pkg::rb_sel_e m_rb;
    radio_core_pkg::pps_src_e m_pps;

    radio_core dut0 (
        .i_radio_clk(radio_clk), .i_bus_rst(bus_rst),
        .i_ctrl(ctrl_beat), .o_ctrl_ready(ctrl_ready),
        .o_resp(resp_beat), .i_resp_ready(resp_ready),
        .i_pps_gpsdo(pps_gpsdo), .i_pps_ext(pps_ext), .i_pps_int(pps_int),
        .o_pps(pps_out), .o_pps_select(pps_sel),
        .i_rb_misc(STATUS_WORD), .o_misc_outs(misc_outs), .i_lock_signals(lock_signals)
    );

    initial begin
        radio_clk = 1'b0;
        forever #5 radio_clk = ~radio_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // response ready, either held high or taken from the LCG
    initial begin
        lcg_state = 32'd84;
        forever begin
            @(negedge radio_clk);
            lcg_state = lcg_next(lcg_state);
            resp_ready = rand_ready ? lcg_state[16] : 1'b1;
        end
    end

    initial begin
        repeat (NUM_TESTS * 200 + 10) @(posedge radio_clk);
        $display("watchdog expired: the DUT stopped answering, run aborted");
        $display("** FAIL **");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_beat(input radio_core_pkg::stream_beat_t got,
                              input radio_core_pkg::stream_beat_t exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("Error at %0t: %s got last %b data %h, expected last %b data %h",
                     $time, what, got.last, got.data, exp.last, exp.data);
        end
    endtask

    task automatic check_misc(input logic [31:0] got, input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("Error at %0t: misc outs got %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_pps(input radio_core_pkg::pps_src_e got_sel,
                             input radio_core_pkg::pps_src_e exp_sel,
                             input logic got_lvl, input logic exp_lvl);
        checks = checks + 1;
        if (got_sel !== exp_sel || got_lvl !== exp_lvl) begin
            errors = errors + 1;
            $display("Error at %0t: pps select %0d level %b, expected select %0d level %b",
                     $time, got_sel, got_lvl, exp_sel, exp_lvl);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus and model helpers
    ////////////////////////////////////////////////////////////////////////////
    function automatic entry_t make_entry(input kind_e kind, input logic [7:0] sid,
                                          input logic [7:0] seq, input logic [7:0] addr,
                                          input logic [31:0] data, input logic [1:0] lock,
                                          input logic [2:0] pps, input logic rand_rdy,
                                          input logic exp_pps);
        return {kind, sid, seq, addr, data, lock, pps, rand_rdy, exp_pps};
    endfunction

    task automatic apply_write(input logic [7:0] addr, input logic [31:0] data);
        case (addr)
            A_MISC: m_misc = data;
            A_RB:   m_rb   = radio_core_pkg::rb_sel_e'(data[1:0]);
            A_SYNC: m_pps  = radio_core_pkg::pps_src_e'(data[1:0]);
            default: ;
        endcase
    endtask

    function automatic logic [63:0] model_readback(input logic [1:0] lock);
        case (m_rb)
            radio_core_pkg::RB_COMPAT: return {radio_core_pkg::COMPAT_SIGNATURE,
                                               radio_core_pkg::COMPAT_MAJOR,
                                               radio_core_pkg::COMPAT_MINOR};
            radio_core_pkg::RB_MISC:   return {32'd0, m_misc};
            radio_core_pkg::RB_STATUS: return {32'd0, STATUS_WORD};
            default:                   return {62'd0, lock};
        endcase
    endfunction

    task automatic send_word(input logic [63:0] data, input logic last);
        @(negedge radio_clk);
        ctrl_beat = {1'b1, last, data};
        @(posedge radio_clk);
        while (!ctrl_ready) @(posedge radio_clk);
    endtask

    task automatic send_packet(input logic [63:0] hdr, input logic [63:0] body);
        send_word(hdr, 1'b0);
        send_word(body, 1'b1);
        @(negedge radio_clk);
        ctrl_beat = '0;
    endtask

    task automatic recv_beat(output radio_core_pkg::stream_beat_t beat);
        @(posedge radio_clk);
        while (!(resp_beat.valid && resp_ready)) @(posedge radio_clk);
        beat = resp_beat;
    endtask

    task automatic expect_packet(input radio_core_pkg::stream_beat_t exp_hdr,
                                 input radio_core_pkg::stream_beat_t exp_dat);
        radio_core_pkg::stream_beat_t beat;
        recv_beat(beat);
        check_beat(beat, exp_hdr, "response header");
        recv_beat(beat);
        check_beat(beat, exp_dat, "response data");
    endtask

    // watches the whole send and the cycles after it
    task automatic expect_silence(input int cycles);
        checks = checks + 1;
        repeat (cycles) begin
            @(posedge radio_clk);
            if (resp_beat.valid) begin
                errors = errors + 1;
                $display("Error at %0t: response seen for a discarded packet", $time);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin : main
        entry_t                       e;
        logic [63:0]                  hdr;
        logic [63:0]                  body;
        radio_core_pkg::stream_beat_t exp_hdr;
        radio_core_pkg::stream_beat_t exp_dat;
        int                           err_before;

        bus_rst = 1'b1;
        ctrl_beat = '0;
        resp_ready = 1'b1;
        rand_ready = 1'b0;
        {pps_int, pps_ext, pps_gpsdo} = 3'b000;
        lock_signals = 2'b00;
        errors = 0;
        checks = 0;
        m_misc = 32'd0;
        m_rb = radio_core_pkg::RB_COMPAT;
        m_pps = radio_core_pkg::PPS_GPSDO;

        tbl[0]  = make_entry(K_CORE,    8'h40, 8'h01, A_RB,   32'd0,        2'b00, 3'b000, 0, 0);
        tbl[1]  = make_entry(K_CORE,    8'h41, 8'h02, A_MISC, 32'hdeadbeef, 2'b00, 3'b001, 0, 1);
        tbl[2]  = make_entry(K_CORE,    8'h40, 8'h03, A_RB,   32'd1,        2'b00, 3'b001, 0, 1);
        tbl[3]  = make_entry(K_CORE,    8'h40, 8'h04, A_RB,   32'd2,        2'b00, 3'b000, 0, 0);
        tbl[4]  = make_entry(K_CORE,    8'h40, 8'h05, A_RB,   32'd3,        2'b10, 3'b000, 0, 0);
        tbl[5]  = make_entry(K_CORE,    8'h4f, 8'h06, A_MISC, 32'h00000084, 2'b01, 3'b000, 0, 0);
        tbl[6]  = make_entry(K_CORE,    8'h40, 8'h07, A_SYNC, 32'd1,        2'b01, 3'b010, 0, 1);
        tbl[7]  = make_entry(K_CORE,    8'h40, 8'h08, A_SYNC, 32'd2,        2'b01, 3'b011, 0, 0);
        tbl[8]  = make_entry(K_CORE,    8'h40, 8'h09, A_SYNC, 32'd3,        2'b01, 3'b111, 0, 0);
        tbl[9]  = make_entry(K_CORE,    8'h40, 8'h0a, A_SYNC, 32'd0,        2'b01, 3'b101, 0, 1);
        tbl[10] = make_entry(K_LOOP,    8'h20, 8'h0b, 8'h12,  32'h0badcafe, 2'b01, 3'b101, 0, 1);
        tbl[11] = make_entry(K_UNKNOWN, 8'h10, 8'h0c, A_MISC, 32'hffffffff, 2'b01, 3'b101, 0, 1);
        tbl[12] = make_entry(K_LOOP,    8'h2a, 8'h0d, 8'h34,  32'h600df00d, 2'b01, 3'b101, 1, 1);
        tbl[13] = make_entry(K_CORE,    8'h40, 8'h0e, A_RB,   32'd1,        2'b01, 3'b101, 1, 1);
        tbl[14] = make_entry(K_UNKNOWN, 8'h80, 8'h0f, A_MISC, 32'h0,        2'b01, 3'b101, 1, 1);
        tbl[15] = make_entry(K_CORE,    8'h40, 8'h10, A_MISC, 32'h13579bdf, 2'b01, 3'b100, 1, 0);
        tbl[16] = make_entry(K_LOOP,    8'h20, 8'h11, 8'h56,  32'h2468ace0, 2'b01, 3'b100, 1, 0);
        tbl[17] = make_entry(K_CORE,    8'h40, 8'h12, A_RB,   32'd0,        2'b01, 3'b100, 1, 0);

        repeat (2) @(posedge radio_clk);
        @(negedge radio_clk);
        bus_rst = 1'b0;

        for (int i = 0; i < NUM_TESTS; i++) begin
            e = tbl[i];
            err_before = errors;
            @(negedge radio_clk);
            lock_signals = e.lock;
            {pps_int, pps_ext, pps_gpsdo} = e.pps;
            rand_ready = e.rand_rdy;
            // let the synchronizers settle
            repeat (4) @(negedge radio_clk);
            hdr  = {40'd0, e.seq, 8'd0, e.sid};
            body = {24'd0, e.addr, e.data};
            case (e.kind)
                K_CORE: begin
                    apply_write(e.addr, e.data);
                    exp_hdr = {1'b1, 1'b0, 40'd0, e.seq, 8'd0, radio_core_pkg::SID_RESP};
                    exp_dat = {1'b1, 1'b1, model_readback(e.lock)};
                    fork
                        send_packet(hdr, body);
                        expect_packet(exp_hdr, exp_dat);
                    join
                end
                K_LOOP: begin
                    fork
                        send_packet(hdr, body);
                        expect_packet({1'b1, 1'b0, hdr}, {1'b1, 1'b1, body});
                    join
                end
                default: begin
                    fork
                        send_packet(hdr, body);
                        expect_silence(8);
                    join
                end
            endcase
            @(posedge radio_clk);
            check_misc(misc_outs, m_misc);
            check_pps(pps_sel, m_pps, pps_out, e.exp_pps);
            $display("test %0d %s seq %h: %s", i, e.kind.name(), e.seq,
                     (errors == err_before) ? "ok" : "mismatch");
        end

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
